//--- ctrl_pkg.sv
package ctrl_pkg;

  typedef enum logic [2:0] {
    st_fetch,
    st_decode,
    st_mem1,
    st_exec1,
    st_exec2,
    st_invalid
  } seq_state_t;

  typedef enum logic [1:0] {
    src_mem_data,
    src_acc,
    src_x,
    src_alu_result
  } data_src_t;

  typedef enum logic {
    addr_pc,
    addr_reg
  } addr_src_t;

  typedef enum logic [1:0] {
    alu_add,
    alu_and,
    alu_or,
    alu_xor
  } alu_op_t;

  typedef enum logic [1:0] {
    carry_keep,
    carry_clear,
    carry_set,
    carry_update
  } carry_act_t;

  typedef struct packed {
    data_src_t  data_src;
    addr_src_t  addr_src;
    logic       load_ir;
    logic       load_acc;
    logic       load_x;
    logic       load_operand;
    logic       load_addr_low;
    logic       load_addr_high;
    logic       inc_pc;
    logic       load_pc;
    logic       mem_we;
    alu_op_t    alu_op;
    logic       invert_b;
    logic       alu_carry_in; // carry flag into the adder for adc and sbc.
    carry_act_t carry_act;
  } ctrl_word_t;

  localparam ctrl_word_t ctrl_idle = '{
    data_src:       src_mem_data,
    addr_src:       addr_pc,
    load_ir:        1'b0,
    load_acc:       1'b0,
    load_x:         1'b0,
    load_operand:   1'b0,
    load_addr_low:  1'b0,
    load_addr_high: 1'b0,
    inc_pc:         1'b0,
    load_pc:        1'b0,
    mem_we:         1'b0,
    alu_op:         alu_add,
    invert_b:       1'b0,
    alu_carry_in:   1'b0,
    carry_act:      carry_keep
  };

endpackage

//--- isa_pkg.sv
package isa_pkg;

  localparam int data_w = 8;
  localparam int addr_w = 16;

  typedef logic [data_w-1:0] data_t;
  typedef logic [addr_w-1:0] addr_t;

  typedef enum logic [7:0] {
    op_ora_imm = 8'h09,
    op_ora_abs = 8'h0D,
    op_clc     = 8'h18,
    op_and_imm = 8'h29,
    op_and_abs = 8'h2D,
    op_sec     = 8'h38,
    op_eor_imm = 8'h49,
    op_jmp_abs = 8'h4C,
    op_eor_abs = 8'h4D,
    op_adc_imm = 8'h69,
    op_adc_abs = 8'h6D,
    op_sta_abs = 8'h8D,
    op_stx_abs = 8'h8E,
    op_ldx_imm = 8'hA2,
    op_lda_imm = 8'hA9,
    op_lda_abs = 8'hAD,
    op_ldx_abs = 8'hAE,
    op_sbc_imm = 8'hE9,
    op_nop     = 8'hEA,
    op_sbc_abs = 8'hED
  } opcode_t;

  typedef enum logic [1:0] {
    mode_imp,
    mode_imm,
    mode_abs
  } addr_mode_t;

  typedef enum logic [2:0] {
    class_load,
    class_store,
    class_arith,
    class_logic,
    class_carry_op,
    class_jump,
    class_nop,
    class_invalid
  } op_class_t;

  typedef enum logic {
    dest_acc,
    dest_x
  } dest_t;

  import ctrl_pkg::*;

  typedef struct packed {
    addr_mode_t addr_mode;
    op_class_t  op_class;
    alu_op_t    alu_op;
    dest_t      dest;      // register for loads and stores.
    logic       invert_b;
    carry_act_t carry_act;
  } decoded_t;

endpackage

//--- alu.sv
`timescale 1ns/1ps

module alu import ctrl_pkg::*, isa_pkg::*; (
  input  alu_op_t op,
  input  data_t   a,
  input  data_t   b,
  input  logic    invert_b,
  input  logic    carry_in,
  output data_t   result,
  output logic    carry_out
);

  data_t             b_eff;
  logic [data_w:0]   sum;

  assign b_eff = invert_b ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, b_eff} + {{data_w{1'b0}}, carry_in};

  always_comb begin
    result    = sum[data_w-1:0];
    carry_out = carry_in; // logic ops pass it through.
    case (op)
      alu_add: carry_out = sum[data_w];
      alu_and: result    = a & b;
      alu_or:  result    = a | b;
      alu_xor: result    = a ^ b;
      default: result    = sum[data_w-1:0];
    endcase
  end

endmodule

//--- instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import ctrl_pkg::*, isa_pkg::*; (
  input  data_t    ir,
  output decoded_t dec
);

  always_comb begin
    dec.addr_mode = mode_imp;
    dec.op_class  = class_invalid;
    dec.alu_op    = alu_add;
    dec.dest      = dest_acc;
    dec.invert_b  = 1'b0;
    dec.carry_act = carry_keep;

    case (ir)
      op_lda_imm, op_ldx_imm, op_adc_imm, op_sbc_imm,
      op_and_imm, op_ora_imm, op_eor_imm: dec.addr_mode = mode_imm;
      op_lda_abs, op_ldx_abs, op_adc_abs, op_sbc_abs,
      op_and_abs, op_ora_abs, op_eor_abs,
      op_sta_abs, op_stx_abs, op_jmp_abs: dec.addr_mode = mode_abs;
      default: dec.addr_mode = mode_imp;
    endcase

    case (ir)
      op_lda_imm, op_lda_abs: dec.op_class = class_load;
      op_ldx_imm, op_ldx_abs: begin
        dec.op_class = class_load;
        dec.dest     = dest_x;
      end
      op_sta_abs: dec.op_class = class_store;
      op_stx_abs: begin
        dec.op_class = class_store;
        dec.dest     = dest_x;
      end
      op_adc_imm, op_adc_abs: begin
        dec.op_class  = class_arith;
        dec.carry_act = carry_update;
      end
      op_sbc_imm, op_sbc_abs: begin
        dec.op_class  = class_arith;
        dec.invert_b  = 1'b1; // a + ~m + c.
        dec.carry_act = carry_update;
      end
      op_and_imm, op_and_abs: begin
        dec.op_class = class_logic;
        dec.alu_op   = alu_and;
      end
      op_ora_imm, op_ora_abs: begin
        dec.op_class = class_logic;
        dec.alu_op   = alu_or;
      end
      op_eor_imm, op_eor_abs: begin
        dec.op_class = class_logic;
        dec.alu_op   = alu_xor;
      end
      op_clc: begin
        dec.op_class  = class_carry_op;
        dec.carry_act = carry_clear;
      end
      op_sec: begin
        dec.op_class  = class_carry_op;
        dec.carry_act = carry_set;
      end
      op_jmp_abs: dec.op_class = class_jump;
      op_nop:     dec.op_class = class_nop;
      default:    dec.op_class = class_invalid;
    endcase
  end

endmodule

//--- control_sequencer.sv
`timescale 1ns/1ps

module control_sequencer import ctrl_pkg::*, isa_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  data_t      mem_rdata,
  input  decoded_t   dec,
  input  logic       carry,
  output data_t      ir,
  output ctrl_word_t ctrl,
  output logic       halted
);

  seq_state_t state;
  seq_state_t next_state;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_fetch;
      ir    <= op_nop;
    end else begin
      state <= next_state;
      if (ctrl.load_ir) begin
        ir <= mem_rdata;
      end
    end
  end

  always_comb begin
    ctrl       = ctrl_idle;
    next_state = st_invalid;

    case (state)
      st_fetch: begin
        ctrl.load_ir   = 1'b1;
        ctrl.inc_pc    = 1'b1;
        next_state     = st_decode;
      end
      st_decode: begin
        case (dec.op_class)
          class_nop:     next_state = st_fetch;
          class_invalid: next_state = st_invalid;
          default: begin
            if (dec.addr_mode == mode_abs) begin
              ctrl.load_addr_low = 1'b1; // low byte follows the opcode.
              ctrl.inc_pc        = 1'b1;
              next_state         = st_mem1;
            end else begin
              next_state = st_exec1;
            end
          end
        endcase
      end
      st_mem1: begin
        ctrl.load_addr_high = 1'b1;
        ctrl.inc_pc         = 1'b1;
        next_state          = st_exec1;
      end
      st_exec1: begin
        next_state = st_fetch;
        if (dec.addr_mode == mode_abs) begin
          ctrl.addr_src = addr_reg;
        end
        if (dec.addr_mode == mode_imm) begin
          ctrl.inc_pc = 1'b1; // step past the immediate byte.
        end
        case (dec.op_class)
          class_load: begin
            ctrl.load_acc = (dec.dest == dest_acc);
            ctrl.load_x   = (dec.dest == dest_x);
          end
          class_store: begin
            ctrl.data_src = (dec.dest == dest_x) ? src_x : src_acc;
            ctrl.mem_we   = 1'b1;
          end
          class_jump:     ctrl.load_pc   = 1'b1;
          class_carry_op: ctrl.carry_act = dec.carry_act;
          class_arith, class_logic: begin
            ctrl.load_operand = 1'b1;
            next_state        = st_exec2;
          end
          default: next_state = st_invalid;
        endcase
      end
      st_exec2: begin
        ctrl.data_src     = src_alu_result;
        ctrl.load_acc     = 1'b1;
        ctrl.alu_op       = dec.alu_op;
        ctrl.invert_b     = dec.invert_b;
        ctrl.alu_carry_in = (dec.op_class == class_arith) && carry;
        ctrl.carry_act    = dec.carry_act; // keep for logic ops.
        next_state        = st_fetch;
      end
      default: next_state = st_invalid; // sticky until reset.
    endcase
  end

  assign halted = (state == st_invalid);

endmodule

//--- data_path.sv
`timescale 1ns/1ps

module data_path import ctrl_pkg::*, isa_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  ctrl_word_t ctrl,
  input  data_t      mem_rdata,
  output data_t      wdata,
  output logic       carry
);

  data_t acc;
  data_t x_reg;
  data_t operand;
  data_t data_bus;
  data_t alu_result;
  logic  alu_carry;

  alu u_alu (
    .op        (ctrl.alu_op),
    .a         (acc),
    .b         (operand),
    .invert_b  (ctrl.invert_b),
    .carry_in  (ctrl.alu_carry_in),
    .result    (alu_result),
    .carry_out (alu_carry)
  );

  always_comb begin
    case (ctrl.data_src)
      src_mem_data:   data_bus = mem_rdata;
      src_acc:        data_bus = acc;
      src_x:          data_bus = x_reg;
      src_alu_result: data_bus = alu_result;
      default:        data_bus = mem_rdata;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      acc   <= '0;
      x_reg <= '0;
      carry <= 1'b0;
    end else begin
      if (ctrl.load_acc) begin
        acc <= data_bus;
      end
      if (ctrl.load_x) begin
        x_reg <= data_bus;
      end
      case (ctrl.carry_act)
        carry_clear:  carry <= 1'b0;
        carry_set:    carry <= 1'b1;
        carry_update: carry <= alu_carry;
        default:      carry <= carry;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.load_operand) begin
      operand <= data_bus; // b side of the alu.
    end
  end

  assign wdata = (ctrl.data_src == src_x) ? x_reg : acc;

endmodule

//--- address_unit.sv
`timescale 1ns/1ps

module address_unit import ctrl_pkg::*, isa_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  ctrl_word_t ctrl,
  input  data_t      mem_rdata,
  output addr_t      mem_addr
);

  addr_t pc;
  data_t addr_low;
  data_t addr_high;
  addr_t addr_regs;

  assign addr_regs = {addr_high, addr_low};

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (ctrl.load_pc) begin
      pc <= addr_regs; // jmp target.
    end else if (ctrl.inc_pc) begin
      pc <= pc + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.load_addr_low) begin
      addr_low <= mem_rdata;
    end
    if (ctrl.load_addr_high) begin
      addr_high <= mem_rdata;
    end
  end

  always_comb begin
    case (ctrl.addr_src)
      addr_reg: mem_addr = addr_regs;
      default:  mem_addr = pc;
    endcase
  end

endmodule

//--- cpu_top.sv
`timescale 1ns/1ps

module cpu_top import ctrl_pkg::*, isa_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  output addr_t mem_addr,
  input  data_t mem_rdata,
  output data_t mem_wdata,
  output logic  mem_we,
  output logic  halted
);

  data_t      ir;
  decoded_t   dec;
  ctrl_word_t ctrl;
  logic       carry;

  control_sequencer u_seq (
    .clk       (clk),
    .reset     (reset),
    .mem_rdata (mem_rdata),
    .dec       (dec),
    .carry     (carry),
    .ir        (ir),
    .ctrl      (ctrl),
    .halted    (halted)
  );

  instr_decoder u_dec (
    .ir  (ir),
    .dec (dec)
  );

  data_path u_dp (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl),
    .mem_rdata (mem_rdata),
    .wdata     (mem_wdata),
    .carry     (carry)
  );

  address_unit u_au (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl),
    .mem_rdata (mem_rdata),
    .mem_addr  (mem_addr)
  );

  assign mem_we = ctrl.mem_we;

endmodule

//--- cpu_tb_sva.sv
`timescale 1ns/1ps

module cpu_tb_sva import isa_pkg::*; (
  input logic  clk,
  input logic  reset,
  input addr_t mem_addr,
  input logic  mem_we,
  input logic  halted
);

  we_low_after_reset: assert property (@(posedge clk) reset |=> !mem_we)
    else $error("mem_we high in the first cycle after reset");

  halted_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
    else $error("halted dropped without a reset");

  no_write_when_halted: assert property (@(posedge clk) disable iff (reset) !(halted && mem_we))
    else $error("memory write while halted");

  addr_stable_when_halted: assert property (
    @(posedge clk) disable iff (reset) halted |=> $stable(mem_addr)
  ) else $error("mem_addr moved while halted");

endmodule

bind cpu_top cpu_tb_sva u_sva (
  .clk      (clk),
  .reset    (reset),
  .mem_addr (mem_addr),
  .mem_we   (mem_we),
  .halted   (halted)
);

//--- cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb import isa_pkg::*; ();

  localparam int halt_timeout = 2000;

  logic  clk;
  logic  reset;
  logic  load_mem;
  addr_t mem_addr;
  data_t mem_rdata;
  data_t mem_wdata;
  logic  mem_we;
  logic  halted;

  data_t mem [256] = '{default: 8'h00};
  data_t image [256];
  data_t ref_mem [256];
  addr_t exp_addr [$];
  data_t exp_data [$];
  data_t kept_ops [20] = '{8'hA9, 8'hA2, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49,
                           8'hAD, 8'hAE, 8'h6D, 8'hED, 8'h2D, 8'h0D, 8'h4D, 8'h8D, 8'h8E,
                           8'h18, 8'h38, 8'hEA, 8'h4C};
  string test_name;
  int    wr_ptr;
  int    checks;
  int    value_errors;
  int    other_errors;
  bit    timed_out;

  cpu_top UUT (
    .clk       (clk),
    .reset     (reset),
    .mem_addr  (mem_addr),
    .mem_rdata (mem_rdata),
    .mem_wdata (mem_wdata),
    .mem_we    (mem_we),
    .halted    (halted)
  );

  always #10 clk = ~clk;

  assign mem_rdata = mem[mem_addr[7:0]]; // same-cycle read.

  always @(posedge clk) begin
    if (load_mem) begin
      mem <= image;
    end else if (mem_we === 1'b1) begin
      mem[mem_addr[7:0]] <= mem_wdata;
    end
  end

  task automatic check_addr(input string name, input addr_t expected, input addr_t actual);
    checks++;
    if (actual !== expected) begin
      value_errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_data(input string name, input data_t expected, input data_t actual);
    checks++;
    if (actual !== expected) begin
      value_errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      value_errors++;
      $display("CHECK FAILED %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // every write is matched in order against the reference.
  always @(posedge clk) begin
    if (!reset && mem_we === 1'b1) begin
      if (exp_addr.size() == 0) begin
        other_errors++;
        $display("%s: unexpected write of %h to %h", test_name, mem_wdata, mem_addr);
      end else begin
        check_addr({test_name, " write address"}, exp_addr.pop_front(), mem_addr);
        check_data({test_name, " write data"}, exp_data.pop_front(), mem_wdata);
      end
    end
  end

  function automatic data_t byte_at(input addr_t addr);
    return ref_mem[addr[7:0]];
  endfunction

  // returns true once the instruction-set model reaches an unknown opcode.
  function automatic bit run_reference();
    data_t a;
    data_t x;
    data_t m;
    data_t op;
    logic  c;
    addr_t pc;
    addr_t ea;
    int    step;
    a  = '0;
    x  = '0;
    m  = '0;
    c  = 1'b0;
    pc = '0;
    ea = '0;
    for (step = 0; step < 1000; step++) begin
      op = byte_at(pc);
      case (op)
        8'hA9, 8'hA2, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49: begin
          m  = byte_at(pc + 16'd1);
          pc = pc + 16'd2;
        end
        8'hAD, 8'hAE, 8'h6D, 8'hED, 8'h2D, 8'h0D, 8'h4D, 8'h8D, 8'h8E, 8'h4C: begin
          ea = {byte_at(pc + 16'd2), byte_at(pc + 16'd1)};
          m  = byte_at(ea);
          pc = pc + 16'd3;
        end
        default: pc = pc + 16'd1;
      endcase
      case (op)
        8'hA9, 8'hAD: a = m;
        8'hA2, 8'hAE: x = m;
        8'h8D, 8'h8E: begin
          ref_mem[ea[7:0]] = (op == 8'h8D) ? a : x;
          exp_addr.push_back(ea);
          exp_data.push_back(ref_mem[ea[7:0]]);
        end
        8'h69, 8'h6D: {c, a} = {1'b0, a} + {1'b0, m} + {8'h00, c};
        8'hE9, 8'hED: {c, a} = {1'b0, a} + {1'b0, ~m} + {8'h00, c};
        8'h29, 8'h2D: a = a & m;
        8'h09, 8'h0D: a = a | m;
        8'h49, 8'h4D: a = a ^ m;
        8'h18: c = 1'b0;
        8'h38: c = 1'b1;
        8'h4C: pc = ea;
        8'hEA: ;
        default: return 1'b1;
      endcase
    end
    return 1'b0;
  endfunction

  task automatic clear_image();
    int i;
    for (i = 0; i < 256; i++) begin
      image[i] = data_t'(i * 37 + 11);
    end
    wr_ptr = 0;
  endtask

  task automatic emit(input data_t value);
    image[wr_ptr] = value;
    wr_ptr++;
  endtask

  task automatic emit_imm(input data_t op, input data_t value);
    emit(op);
    emit(value);
  endtask

  task automatic emit_abs(input data_t op, input data_t low);
    emit(op);
    emit(low);
    emit(8'h00);
  endtask

  task automatic run_program(input string name);
    int cycles;
    if (timed_out) return;
    test_name = name;
    ref_mem   = image;
    exp_addr.delete();
    exp_data.delete();
    if (!run_reference()) begin
      other_errors++;
      $display("%s: reference model never reached an invalid opcode", name);
    end
    @(posedge clk);
    reset    <= 1'b1;
    load_mem <= 1'b1;
    @(posedge clk);
    load_mem <= 1'b0;
    repeat (3) @(posedge clk);
    reset  <= 1'b0;
    cycles = 0;
    while (halted !== 1'b1 && cycles < halt_timeout) begin
      @(posedge clk);
      cycles++;
    end
    if (halted !== 1'b1) begin
      other_errors++;
      timed_out = 1'b1;
      $display("%s: halted did not rise within %0d cycles", name, halt_timeout);
    end else begin
      repeat (8) @(posedge clk); // nothing may move after the halt.
      check_bit({name, " halted"}, 1'b1, halted);
      if (exp_addr.size() != 0) begin
        other_errors++;
        $display("%s: %0d expected writes never happened", name, exp_addr.size());
      end
    end
  endtask

  task automatic test_load_store();
    clear_image();
    image[8'h80] = 8'h3C;
    image[8'h81] = 8'hC5;
    emit_imm(8'hA9, 8'h5A);
    emit_abs(8'h8D, 8'h90);
    emit_imm(8'hA2, 8'hA7);
    emit_abs(8'h8E, 8'h91);
    emit_abs(8'hAD, 8'h80);
    emit_abs(8'h8D, 8'h92);
    emit_abs(8'hAE, 8'h81);
    emit_abs(8'h8E, 8'h93);
    emit(8'h02);
    run_program("load_store");
  endtask

  task automatic test_arith();
    clear_image();
    image[8'h80] = 8'hFF;
    image[8'h81] = 8'h40;
    emit(8'h38);
    emit_imm(8'hA9, 8'hF0);
    emit_imm(8'h69, 8'h20); // carries out.
    emit_abs(8'h8D, 8'h90);
    emit_abs(8'h6D, 8'h80);
    emit_abs(8'h8D, 8'h91);
    emit(8'h18);
    emit_imm(8'hE9, 8'h05);
    emit_abs(8'h8D, 8'h92);
    emit_abs(8'hED, 8'h81); // borrow.
    emit_abs(8'h8D, 8'h93);
    emit_imm(8'h69, 8'h00);
    emit_abs(8'h8D, 8'h94);
    emit(8'h02);
    run_program("add_sub_carry");
  endtask

  task automatic test_logic();
    clear_image();
    image[8'h80] = 8'h35;
    image[8'h81] = 8'h6E;
    emit(8'h38);
    emit_imm(8'hA9, 8'hCA);
    emit_imm(8'h29, 8'h0F);
    emit_abs(8'h8D, 8'h90);
    emit_abs(8'h0D, 8'h80);
    emit_abs(8'h8D, 8'h91);
    emit_imm(8'h49, 8'hFF);
    emit_abs(8'h4D, 8'h81);
    emit_abs(8'h8D, 8'h92);
    emit_imm(8'h69, 8'h00); // adds the kept carry.
    emit_abs(8'h8D, 8'h93);
    emit(8'h18);
    emit_abs(8'h2D, 8'h80);
    emit_imm(8'h09, 8'h40);
    emit_imm(8'h69, 8'h00);
    emit_abs(8'h8D, 8'h94);
    emit(8'h02);
    run_program("logic_ops");
  endtask

  task automatic test_jump();
    clear_image();
    emit_imm(8'hA9, 8'h11);
    emit_imm(8'hA2, 8'h22);
    emit_abs(8'h4C, 8'h20);
    emit_abs(8'h8D, 8'h90); // skipped block.
    emit_abs(8'h8E, 8'h91);
    wr_ptr = 'h20;
    emit_abs(8'h8E, 8'h92);
    emit_abs(8'h8D, 8'h93);
    emit(8'h02);
    run_program("jump");
  endtask

  task automatic test_invalid();
    clear_image();
    emit_imm(8'hA9, 8'h55);
    emit_abs(8'h8D, 8'h90);
    emit(8'hEA);
    emit(8'h02);
    emit_abs(8'h8D, 8'h91);
    emit(8'h02);
    run_program("invalid_opcode");
  endtask

  task automatic build_random();
    int    k;
    int    sel;
    addr_t target;
    clear_image();
    for (k = 0; k < 16; k++) begin
      sel = $urandom_range(0, 19);
      emit(kept_ops[sel]);
      if (sel <= 6) begin
        emit(data_t'($urandom));
      end else if (sel <= 15) begin
        emit(data_t'($urandom_range(128, 255)));
        emit(8'h00);
      end else if (sel == 19) begin
        target = addr_t'(wr_ptr + 5); // over one store.
        emit(target[7:0]);
        emit(target[15:8]);
        emit_abs(8'h8D, 8'hFF);
      end
    end
    emit(8'h02);
    for (k = 128; k < 256; k++) begin
      image[k] = data_t'($urandom);
    end
  endtask

  initial begin
    int n;
    clk          = 1'b0;
    reset        = 1'b1;
    load_mem     = 1'b0;
    checks       = 0;
    value_errors = 0;
    other_errors = 0;
    timed_out    = 1'b0;
    void'($urandom(57992));
    test_load_store();
    test_arith();
    test_logic();
    test_jump();
    test_invalid();
    for (n = 0; n < 20; n++) begin
      build_random();
      run_program($sformatf("random_%0d", n));
    end
    $display("checks %0d, value errors %0d, other errors %0d",
             checks, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- mini6502.f
ctrl_pkg.sv
isa_pkg.sv
alu.sv
instr_decoder.sv
control_sequencer.sv
data_path.sv
address_unit.sv
cpu_top.sv
cpu_tb_sva.sv
cpu_tb.sv

//--- Makefile
# Verilator build and run for the mini6502 testbench.

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= mini6502.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
